/* la_top.f */
+incdir+verification
source/la_pkg.sv
source/la_freq_div.sv
source/la_trigger_detect.sv
source/la_sample_ctrl.sv
source/la_capture_ram.sv
source/la_wb_regs.sv
source/la_top.sv
verification/la_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := la_tb
FILELIST  := la_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) verification/la_tb_checks.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -F '*** FAILED ***' $(LOG); then exit 1; fi
	@grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/la_tb_checks.svh */
`ifndef LA_TB_CHECKS_SVH
`define LA_TB_CHECKS_SVH

task automatic check_sample(input string name, input logic [LA_DW-1:0] got,
                            input logic [LA_DW-1:0] want);
  if (got !== want) begin
    $display("FAILED %s got 0x%02h expected 0x%02h", name, got, want);
    abort_sim();
  end
endtask

task automatic check_addr(input string name, input logic [LA_AW-1:0] got,
                          input logic [LA_AW-1:0] want);
  if (got !== want) begin
    $display("FAILED %s got 0x%03h expected 0x%03h", name, got, want);
    abort_sim();
  end
endtask

// whole status word, fields shown for quick reading
task automatic check_status(input string name, input la_status_t got,
                            input la_status_t want);
  if (got !== want) begin
    $display("FAILED %s got 0x%03h expected 0x%03h (busy %h/%h finished %h/%h)",
             name, got, want, got.busy, want.busy, got.finished, want.finished);
    abort_sim();
  end
endtask

// polls o_irq once per cycle
task automatic wait_for_irq(input int max_cycles);
  int n;
  n = 0;
  while (!irq) begin
    if (n == max_cycles) begin
      $display("capture did not finish within %0d cycles", max_cycles);
      abort_sim();
    end
    n++;
    @(negedge sys_clk);
  end
endtask

`endif

/* verification/la_tb.sv */
`timescale 1ns/1ps

module la_tb;

  import la_pkg::*;

  localparam int               BUS_TIMEOUT = 16;    // cycles to wait for ack
  localparam int               CAP_TIMEOUT = 20000; // cycles to wait for finished
  localparam logic [WB_AW-1:0] WIN_BASE    = 13'h1000;

  logic             sys_clk = 1'b0;
  logic             arst_n;
  logic [LA_DW-1:0] probe;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [WB_AW-1:0] wb_adr;
  logic [31:0]      wb_dat_w;
  logic [31:0]      wb_dat_r;
  logic             wb_ack;
  logic             irq;

  integer           seed;
  logic [LA_DW-1:0] ack_probe;          // probe value seen with the last ack
  logic [LA_DW-1:0] got_win [LA_DEPTH]; // window as read over the bus
  logic [LA_DW-1:0] exp_win [LA_DEPTH];
  logic [LA_AW-1:0] exp_start;
  logic [LA_DW-1:0] cur_mask;
  logic [LA_DW-1:0] cur_value;
  logic [7:0]       cur_div;
  logic [LA_AW-1:0] cur_pre;
  int               cmp_runs = 0;
  event             win_read;

  la_top dut0 (
    .i_sys_clk (sys_clk),
    .i_arst_n  (arst_n),
    .i_probe   (probe),
    .i_wb_cyc  (wb_cyc),
    .i_wb_stb  (wb_stb),
    .i_wb_we   (wb_we),
    .i_wb_adr  (wb_adr),
    .i_wb_dat  (wb_dat_w),
    .o_wb_dat  (wb_dat_r),
    .o_wb_ack  (wb_ack),
    .o_irq     (irq)
  );

  initial begin
    forever #10 sys_clk = ~sys_clk;
  end

  always @(negedge sys_clk) probe <= probe + 8'd1; // one step per cycle

  task automatic abort_sim();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  `include "la_tb_checks.svh"

  task automatic bus_cycle(input logic we, input logic [WB_AW-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    @(negedge sys_clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    n = 0;
    @(negedge sys_clk);
    while (!wb_ack) begin
      if (n == BUS_TIMEOUT) begin
        $display("no wishbone ack for address 0x%04h", adr);
        abort_sim();
      end
      n++;
      @(negedge sys_clk);
    end
    rdat      = wb_dat_r;
    ack_probe = probe;     // value before this edge's pending step
    @(negedge sys_clk);    // hold cyc through the ack edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input logic [WB_AW-1:0] adr, input logic [31:0] dat);
    logic [31:0] dummy;
    bus_cycle(1'b1, adr, dat, dummy);
  endtask

  task automatic bus_read(input logic [WB_AW-1:0] adr, output logic [31:0] dat);
    bus_cycle(1'b0, adr, 32'd0, dat);
  endtask

  // sample k of a run is first + k*(div+1) and the trigger is the first match from k = pre on
  function automatic void build_ref_window(input logic [LA_DW-1:0] first,
                                           input logic [LA_DW-1:0] mask,
                                           input logic [LA_DW-1:0] value,
                                           input logic [7:0] div,
                                           input logic [LA_AW-1:0] pre);
    int               k;
    int               step;
    logic [LA_DW-1:0] trig;
    step = int'(div) + 1;
    k    = int'(pre);
    trig = '0;
    for (int n = 0; n < 256; n++) begin
      trig = LA_DW'(int'(first) + k * step);
      if ((trig & mask) == (value & mask)) break;
      k++;
    end
    exp_start = LA_AW'(k - int'(pre)); // ring slot of window word 0
    for (int i = 0; i < LA_DEPTH; i++) begin
      exp_win[i] = LA_DW'(int'(trig) + (i - int'(pre)) * step);
    end
  endfunction

  // compares a freshly read window
  always @(win_read) begin
    check_sample("trigger word under mask", got_win[cur_pre] & cur_mask, cur_value & cur_mask);
    for (int i = 0; i < LA_DEPTH; i++) begin
      if (i > 0) begin
        check_sample($sformatf("step into window[%0d]", i), got_win[i] - got_win[i - 1],
                     cur_div + 8'd1);
      end
      check_sample($sformatf("window[%0d]", i), got_win[i], exp_win[i]);
    end
    cmp_runs = cmp_runs + 1;
  end

  task automatic run_capture(input logic [LA_DW-1:0] mask, input logic [LA_DW-1:0] value,
                             input logic [7:0] div, input logic [LA_AW-1:0] pre,
                             input logic poke_pre);
    logic [31:0]      rd;
    logic [31:0]      rd_start;
    logic [LA_DW-1:0] first;
    la_status_t       st;
    la_status_t       want;
    int               runs;
    int               n;
    bus_write(REG_TRIG, {16'd0, value, mask});
    bus_write(REG_DIV, {24'd0, div});
    bus_write(REG_PRE, {22'd0, pre});
    bus_write(REG_CTRL, 32'd1);          // arm has landed by the time this returns
    first = ack_probe + 8'd2;            // arm lands one edge after ack and the first sample one later
    if (poke_pre) bus_write(REG_PRE, {22'd0, ~pre}); // dropped while busy
    wait_for_irq(CAP_TIMEOUT);
    bus_read(REG_CTRL, rd);
    bus_read(REG_START, rd_start);
    build_ref_window(first, mask, value, div, pre);
    check_addr("REG_START", rd_start[LA_AW-1:0], exp_start);
    st   = '{busy: rd[0], finished: rd[1], start_addr: rd_start[LA_AW-1:0]};
    want = '{busy: 1'b0, finished: 1'b1, start_addr: exp_start};
    check_status("status after capture", st, want);
    if (poke_pre) begin
      bus_read(REG_PRE, rd);
      check_addr("REG_PRE", rd[LA_AW-1:0], pre);
    end
    for (int i = 0; i < LA_DEPTH; i++) begin
      bus_read(WIN_BASE + WB_AW'(i * 4), rd);
      got_win[i] = rd[LA_DW-1:0];
    end
    cur_mask  = mask;
    cur_value = value;
    cur_div   = div;
    cur_pre   = pre;
    runs      = cmp_runs;
    -> win_read;
    n = 0;
    while (cmp_runs == runs) begin
      if (n == 4) begin
        $display("window compare did not run");
        abort_sim();
      end
      n++;
      @(negedge sys_clk);
    end
  endtask

  initial begin
    logic [31:0]      rd_ctrl;
    logic [31:0]      rd_start;
    la_status_t       st;
    logic [LA_AW-1:0] pre1;
    logic [LA_AW-1:0] pre2;
    logic [LA_DW-1:0] val1;
    logic [LA_DW-1:0] val2;
    seed     = 32'h8039_5b90;
    arst_n   = 1'b0;
    probe    = '0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (10) @(negedge sys_clk);
    arst_n = 1'b1;

    bus_read(REG_CTRL, rd_ctrl);
    bus_read(REG_START, rd_start);
    st = '{busy: rd_ctrl[0], finished: rd_ctrl[1], start_addr: rd_start[LA_AW-1:0]};
    check_status("status after reset", st, '0);
    check_sample("o_irq after reset", {7'd0, irq}, 8'h00);

    // full mask with every cycle sampled
    val1 = 8'($random(seed));
    pre1 = LA_AW'(1 + {$random(seed)} % 1023);
    run_capture(8'hFF, val1, 8'd0, pre1, 1'b0);

    // upper nibble only with a spacing of four and a new pre_num
    val2 = 8'($random(seed));
    pre2 = LA_AW'((int'(pre1) + {$random(seed)} % 1022) % 1023 + 1);
    run_capture(8'hF0, val2, 8'd3, pre2, 1'b1);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* source/la_top.sv */
`timescale 1ns/1ps

module la_top (
  input  logic                      i_sys_clk,
  input  logic                      i_arst_n,
  input  logic [la_pkg::LA_DW-1:0]  i_probe,
  input  logic                      i_wb_cyc,
  input  logic                      i_wb_stb,
  input  logic                      i_wb_we,
  input  logic [la_pkg::WB_AW-1:0]  i_wb_adr,
  input  logic [31:0]               i_wb_dat,
  output logic [31:0]               o_wb_dat,
  output logic                      o_wb_ack,
  output logic                      o_irq
);

  import la_pkg::*;

  la_cfg_t          cfg;
  la_sample_t       sample;
  la_wr_t           wr;
  la_status_t       status;
  logic             arm;
  logic             clken;
  logic [LA_AW-1:0] rd_addr;
  logic [LA_DW-1:0] rd_data;

  la_wb_regs u_wb_regs (
    .i_sys_clk (i_sys_clk),
    .i_arst_n  (i_arst_n),
    .i_wb_cyc  (i_wb_cyc),
    .i_wb_stb  (i_wb_stb),
    .i_wb_we   (i_wb_we),
    .i_wb_adr  (i_wb_adr),
    .i_wb_dat  (i_wb_dat),
    .o_wb_dat  (o_wb_dat),
    .o_wb_ack  (o_wb_ack),
    .i_status  (status),
    .i_rd_data (rd_data),
    .o_cfg     (cfg),
    .o_arm     (arm),
    .o_rd_addr (rd_addr)
  );

  la_freq_div u_freq_div (
    .i_sys_clk (i_sys_clk),
    .i_arst_n  (i_arst_n),
    .i_run     (status.busy), // timer only runs during capture
    .i_div     (cfg.div),
    .o_clken   (clken)
  );

  la_trigger_detect u_trigger_detect (
    .i_sys_clk (i_sys_clk),
    .i_arst_n  (i_arst_n),
    .i_clken   (clken),
    .i_probe   (i_probe),
    .i_cfg     (cfg),
    .o_sample  (sample)
  );

  la_sample_ctrl u_sample_ctrl (
    .i_sys_clk (i_sys_clk),
    .i_arst_n  (i_arst_n),
    .i_arm     (arm),
    .i_cfg     (cfg),
    .i_sample  (sample),
    .o_wr      (wr),
    .o_status  (status)
  );

  la_capture_ram u_capture_ram (
    .i_sys_clk (i_sys_clk),
    .i_wr      (wr),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  assign o_irq = status.finished; // level, cleared by next arm

endmodule

/* source/la_wb_regs.sv */
`timescale 1ns/1ps

module la_wb_regs (
  input  logic                      i_sys_clk,
  input  logic                      i_arst_n,
  input  logic                      i_wb_cyc,
  input  logic                      i_wb_stb,
  input  logic                      i_wb_we,
  input  logic [la_pkg::WB_AW-1:0]  i_wb_adr,
  input  logic [31:0]               i_wb_dat,
  output logic [31:0]               o_wb_dat,
  output logic                      o_wb_ack,
  input  la_pkg::la_status_t        i_status,
  input  logic [la_pkg::LA_DW-1:0]  i_rd_data,
  output la_pkg::la_cfg_t           o_cfg,
  output logic                      o_arm,
  output logic [la_pkg::LA_AW-1:0]  o_rd_addr
);

  import la_pkg::*;

  logic req;       // new request, not yet acked
  logic win_sel;   // window region 0x1000..0x1FFC
  logic wr_stb;
  logic [31:0] rd_word;

  assign req     = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign win_sel = i_wb_adr[WB_AW-1];
  assign wr_stb  = req && i_wb_we;

  // window index is relative to the trigger window, not the ring
  assign o_rd_addr = i_status.start_addr + i_wb_adr[LA_AW+1:2];

  always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb_ack <= 1'b0;
      o_arm    <= 1'b0;
      o_cfg    <= '{trig_mask: '0, trig_value: '0, pre_num: LA_AW'(1), div: '0};
    end else begin
      o_wb_ack <= req;  // single wait cycle
      o_arm    <= wr_stb && !win_sel && (i_wb_adr == REG_CTRL) && i_wb_dat[0];
      if (wr_stb && !win_sel) begin
        case (i_wb_adr)
          REG_TRIG: begin
            o_cfg.trig_mask  <= i_wb_dat[7:0];
            o_cfg.trig_value <= i_wb_dat[15:8];
          end
          REG_PRE: if (!i_status.busy) o_cfg.pre_num <= i_wb_dat[LA_AW-1:0]; // locked mid-capture
          REG_DIV: o_cfg.div <= i_wb_dat[7:0];
          default: ; // ctrl and start have no stored bits
        endcase
      end
    end
  end

  // read mux, address is held by the master until ack
  always_comb begin
    rd_word = '0;
    if (win_sel) begin
      rd_word[LA_DW-1:0] = i_rd_data; // ram output from last cycle
    end else begin
      case (i_wb_adr)
        REG_CTRL:  rd_word[1:0]       = {i_status.finished, i_status.busy};
        REG_TRIG:  rd_word[15:0]      = {o_cfg.trig_value, o_cfg.trig_mask};
        REG_PRE:   rd_word[LA_AW-1:0] = o_cfg.pre_num;
        REG_DIV:   rd_word[7:0]       = o_cfg.div;
        REG_START: rd_word[LA_AW-1:0] = i_status.start_addr;
        default:   rd_word = '0;
      endcase
    end
  end

  assign o_wb_dat = rd_word;

  a_ack_single: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
    o_wb_ack |=> !o_wb_ack);

  // master must keep cyc up until it sees ack
  a_ack_in_cyc: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
    o_wb_ack |-> i_wb_cyc);

endmodule

/* source/la_capture_ram.sv */
`timescale 1ns/1ps

module la_capture_ram (
  input  logic                      i_sys_clk,
  input  la_pkg::la_wr_t            i_wr,
  input  logic [la_pkg::LA_AW-1:0]  i_rd_addr,
  output logic [la_pkg::LA_DW-1:0]  o_rd_data
);

  import la_pkg::*;

  logic [LA_DW-1:0] mem [LA_DEPTH]; // sample ring

  always_ff @(posedge i_sys_clk) begin
    if (i_wr.en) mem[i_wr.addr] <= i_wr.data;
  end

  // one cycle read latency, lands in the ack cycle
  always_ff @(posedge i_sys_clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

/* source/la_sample_ctrl.sv */
`timescale 1ns/1ps

module la_sample_ctrl (
  input  logic                i_sys_clk,
  input  logic                i_arst_n,
  input  logic                i_arm,
  input  la_pkg::la_cfg_t     i_cfg,
  input  la_pkg::la_sample_t  i_sample,
  output la_pkg::la_wr_t      o_wr,
  output la_pkg::la_status_t  o_status
);

  import la_pkg::*;

  la_state_e        state;
  logic [LA_AW-1:0] wr_addr;    // next ring slot
  logic [LA_AW-1:0] cnt;        // up in prefill, remaining in post
  logic [LA_AW-1:0] start_addr;
  logic             finished;
  logic             capturing;  // states that write the ring
  logic [LA_AW-1:0] post_len;   // samples still due after the trigger

  assign capturing = (state == PREFILL) || (state == WAIT_TRIG) || (state == POST);
  assign post_len  = LA_AW'(LA_DEPTH - 1) - i_cfg.pre_num;

  always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state      <= IDLE;
      wr_addr    <= '0;
      cnt        <= '0;
      start_addr <= '0;
      finished   <= 1'b0;
    end else if (i_arm) begin
      state    <= PREFILL; // restart from any state
      wr_addr  <= '0;
      cnt      <= '0;
      finished <= 1'b0;
    end else if (capturing && i_sample.valid) begin
      wr_addr <= wr_addr + 1'b1; // wraps at ring size
      case (state)
        PREFILL: begin
          cnt <= cnt + 1'b1;
          if (cnt + 1'b1 == i_cfg.pre_num) state <= WAIT_TRIG;
        end
        WAIT_TRIG: begin
          if (i_sample.hit) begin
            start_addr <= wr_addr - i_cfg.pre_num; // trigger sits at pre_num
            cnt        <= post_len;
            if (post_len == '0) begin
              state    <= DONE; // pre_num 1023 fills the window already
              finished <= 1'b1;
            end else begin
              state <= POST;
            end
          end
        end
        POST: begin
          cnt <= cnt - 1'b1;
          if (cnt == LA_AW'(1)) begin
            state    <= DONE;
            finished <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // write in the same cycle the sample shows up
  assign o_wr = '{en: capturing && i_sample.valid, addr: wr_addr, data: i_sample.data};

  assign o_status = '{busy: capturing, finished: finished, start_addr: start_addr};

  // samples only arrive after the timer ran, so busy was already up
  a_wr_in_capture: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
    o_wr.en |-> capturing && $past(o_status.busy));

  a_arm_prefill: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
    i_arm |=> state == PREFILL);

endmodule

/* source/la_trigger_detect.sv */
`timescale 1ns/1ps

module la_trigger_detect (
  input  logic                      i_sys_clk,
  input  logic                      i_arst_n,
  input  logic                      i_clken,
  input  logic [la_pkg::LA_DW-1:0]  i_probe,
  input  la_pkg::la_cfg_t           i_cfg,
  output la_pkg::la_sample_t        o_sample
);

  import la_pkg::*;

  logic             valid_q;
  logic             hit_q;
  logic [LA_DW-1:0] data_q;  // sampled probe
  logic             match;

  // masked compare on the live probe
  assign match = (i_probe & i_cfg.trig_mask) == (i_cfg.trig_value & i_cfg.trig_mask);

  always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= 1'b0;
      hit_q   <= 1'b0;
    end else begin
      valid_q <= i_clken;          // one cycle after enable
      if (i_clken) hit_q <= match; // flag travels with data
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (i_clken) data_q <= i_probe;
  end

  assign o_sample = '{valid: valid_q, data: data_q, hit: hit_q};

endmodule

/* source/la_freq_div.sv */
`timescale 1ns/1ps

module la_freq_div (
  input  logic       i_sys_clk,
  input  logic       i_arst_n,
  input  logic       i_run,   // busy from controller
  input  logic [7:0] i_div,   // spacing is div+1 cycles
  output logic       o_clken
);

  logic [7:0] cnt; // down-counter, fires at zero

  // held at zero while idle so the first enable comes on the first run cycle
  always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt <= '0;
    end else if (!i_run) begin
      cnt <= '0;
    end else if (cnt == '0) begin
      cnt <= i_div; // reload
    end else begin
      cnt <= cnt - 8'd1;
    end
  end

  // div 0 gives an enable every cycle
  assign o_clken = i_run && (cnt == '0);

endmodule

/* source/la_pkg.sv */
package la_pkg;

  localparam int LA_DEPTH = 1024; // ring entries
  localparam int LA_AW    = 10;   // ring address width
  localparam int LA_DW    = 8;    // probe width
  localparam int WB_AW    = 13;   // wishbone byte address width

  // capture controller states
  typedef enum logic [2:0] {
    IDLE,      // waiting for arm
    PREFILL,   // collecting pre_num samples
    WAIT_TRIG, // ring running, looking for pattern
    POST,      // filling the rest of the window
    DONE       // window complete
  } la_state_e;

  // register byte offsets, window lives at 0x1000 and up
  typedef enum logic [WB_AW-1:0] {
    REG_CTRL  = 13'h000, // w: arm strobe, r: busy/finished
    REG_TRIG  = 13'h004, // mask 7:0, value 15:8
    REG_PRE   = 13'h008, // pre-trigger sample count
    REG_DIV   = 13'h00C, // sample divider
    REG_START = 13'h010  // window start in ring
  } la_reg_e;

  typedef struct packed {
    logic [LA_DW-1:0] trig_mask;
    logic [LA_DW-1:0] trig_value;
    logic [LA_AW-1:0] pre_num;
    logic [7:0]       div;
  } la_cfg_t;

  typedef struct packed {
    logic             valid; // one cycle per clken
    logic [LA_DW-1:0] data;
    logic             hit;   // pattern matched
  } la_sample_t;

  typedef struct packed {
    logic             en;
    logic [LA_AW-1:0] addr;
    logic [LA_DW-1:0] data;
  } la_wr_t;

  typedef struct packed {
    logic             busy;
    logic             finished;
    logic [LA_AW-1:0] start_addr;
  } la_status_t;

endpackage
